//--- hdl/sd_pkg.sv
// sd protocol constants for spi-mode single block reads
// cmd17 frame union, plus the state codes of the spi reader fsm
package sd_pkg;

  // one data block
  localparam int SECTOR_BYTES = 512;
  // system clocks per half sd clock period
  localparam int CLK_DIV = 2;

  localparam logic [5:0] CMD17_INDEX = 6'd17;
  // start-of-data token for single block reads
  localparam logic [7:0] DATA_TOKEN = 8'hFE;

  // polling limits, counted in whole bytes
  localparam int TOKEN_WAIT_MAX = 1024;
  localparam int R1_WAIT_MAX = 8;

  // reader fsm encodings
  localparam logic [2:0] RD_IDLE = 3'd0;
  localparam logic [2:0] RD_CMD = 3'd1;
  localparam logic [2:0] RD_R1 = 3'd2;
  localparam logic [2:0] RD_TOKEN = 3'd3;
  localparam logic [2:0] RD_DATA = 3'd4;
  localparam logic [2:0] RD_CRC = 3'd5;

  // 48-bit command frame
  // built through the field view, sent msb byte first through the byte view
  typedef union packed {
    struct packed {
      logic        start;
      logic        tx;
      logic [5:0]  index;
      logic [31:0] arg;
      logic [6:0]  crc;
      logic        stop;
    } f;
    logic [5:0][7:0] b;
  } sd_cmd_frame_u;

endpackage

//--- hdl/host_pkg.sv
// host side definitions
// command codes and lane count
package host_pkg;

  // number of independent card lanes
  localparam int NUM_LANES = 2;
  // width of the lane select
  localparam int LANE_W = 1;

  // host commands, same coding as the single card reader
  // idle, start a sector read, step the read pointer
  typedef enum logic [1:0] {
    CMD_IDLE = 2'd0,
    CMD_READ = 2'd1,
    CMD_NEXT = 2'd2
  } host_cmd_e;

endpackage

//--- hdl/lane_ctl_if.sv
// per-lane control bundle between dispatcher, lane and collector
`timescale 1ns/1ps

interface lane_ctl_if;

  // one-cycle strobes from the dispatcher
  logic        start;
  logic        next;
  // sector address, held stable by the dispatcher
  logic [31:0] sector;

  // buffer byte at the lane read pointer
  logic [7:0]  data;
  // high while a sector read is running
  logic        busy;
  // sticky, cleared by the next read
  logic        err;

  modport disp (
    output start,
    output next,
    output sector
  );

  modport lane (
    input  start,
    input  next,
    input  sector,
    output data,
    output busy,
    output err
  );

  modport coll (
    input data,
    input busy,
    input err
  );

endinterface

//--- hdl/cmd_dispatch.sv
// host command register and per-lane strobe routing
`timescale 1ns/1ps

module cmd_dispatch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  host_pkg::host_cmd_e           cmd_i,
  input  logic [host_pkg::LANE_W-1:0]   lane_sel_i,
  input  logic [31:0]                   sector_address_i,
  lane_ctl_if.disp                      lanes_o [host_pkg::NUM_LANES]
);

  host_pkg::host_cmd_e               cmd_q;
  logic [host_pkg::LANE_W-1:0]       sel_q;
  logic [31:0]                       sector_q;
  logic [host_pkg::NUM_LANES-1:0]    start_v;
  logic [host_pkg::NUM_LANES-1:0]    next_v;

  // command and lane select, sampled every cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_q <= host_pkg::CMD_IDLE;
      sel_q <= '0;
    end else begin
      cmd_q <= cmd_i;
      sel_q <= lane_sel_i;
    end
  end

  // address only moves with a read, so it stays put for the lanes
  always_ff @(posedge clk) begin
    if (cmd_i == host_pkg::CMD_READ) begin
      sector_q <= sector_address_i;
    end
  end

  // decode the registered command onto the selected lane
  always_comb begin
    start_v = '0;
    next_v  = '0;
    start_v[sel_q] = (cmd_q == host_pkg::CMD_READ);
    next_v[sel_q]  = (cmd_q == host_pkg::CMD_NEXT);
  end

  for (genvar g = 0; g < host_pkg::NUM_LANES; g++) begin : g_route
    assign lanes_o[g].start  = start_v[g];
    assign lanes_o[g].next   = next_v[g];
    assign lanes_o[g].sector = sector_q;
  end

  // never more than one strobe across all lanes
  a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({start_v, next_v}));

endmodule

//--- hdl/sd_spi_reader.sv
// spi-mode single block reader
// sends cmd17, polls r1 and the data token, streams 512 bytes out
`timescale 1ns/1ps

module sd_spi_reader (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  logic [31:0] sector_i,
  output logic        busy_o,
  output logic        done_o,
  output logic        fail_o,
  output logic        byte_en_o,
  output logic [8:0]  byte_addr_o,
  output logic [7:0]  byte_o,
  output logic        sd_clk_o,
  output logic        sd_mosi_o,
  output logic        sd_cs_n_o,
  input  logic        sd_miso_i
);

  logic [2:0]            state_q;
  logic [7:0]            div_cnt_q;
  logic                  sclk_q;
  logic                  cs_n_q;
  logic                  xfer_q;
  logic [2:0]            bit_cnt_q;
  logic [7:0]            tx_q;
  logic [7:0]            rx_q;
  // frame bytes left, poll count or data index depending on state
  logic [10:0]           cnt_q;
  sd_pkg::sd_cmd_frame_u cmd_frame;
  sd_pkg::sd_cmd_frame_u frame_q;
  logic                  tick;
  logic                  byte_fin;
  logic                  fin_ok;
  logic                  fin_fail;

  // cmd17 frame from the requested sector
  always_comb begin
    cmd_frame.f.start = 1'b0;
    cmd_frame.f.tx    = 1'b1;
    cmd_frame.f.index = sd_pkg::CMD17_INDEX;
    cmd_frame.f.arg   = sector_i;
    // crc is ignored by cards in spi mode
    cmd_frame.f.crc   = 7'h7F;
    cmd_frame.f.stop  = 1'b1;
  end

  // half period tick while a byte is in flight
  assign tick = xfer_q && (div_cnt_q == 8'(sd_pkg::CLK_DIV - 1));
  // falling edge that ends bit 7
  assign byte_fin = tick && sclk_q && (bit_cnt_q == 3'd7);

  // early end, r1 error or a poll limit hit
  always_comb begin
    fin_fail = 1'b0;
    if (byte_fin) begin
      case (state_q)
        sd_pkg::RD_R1:
          fin_fail = rx_q[7] ? (cnt_q == 11'(sd_pkg::R1_WAIT_MAX - 1)) : (rx_q != 8'h00);
        sd_pkg::RD_TOKEN:
          fin_fail = (rx_q != sd_pkg::DATA_TOKEN) &&
                     (cnt_q == 11'(sd_pkg::TOKEN_WAIT_MAX - 1));
        default:
          fin_fail = 1'b0;
      endcase
    end
  end

  // second crc byte closes a good read
  assign fin_ok = byte_fin && (state_q == sd_pkg::RD_CRC) && (cnt_q == 11'd1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= sd_pkg::RD_IDLE;
      div_cnt_q <= '0;
      sclk_q    <= 1'b0;
      cs_n_q    <= 1'b1;
      xfer_q    <= 1'b0;
      bit_cnt_q <= '0;
      tx_q      <= 8'hFF;
      cnt_q     <= '0;
      done_o    <= 1'b0;
      fail_o    <= 1'b0;
      byte_en_o <= 1'b0;
    end else begin
      done_o    <= 1'b0;
      byte_en_o <= 1'b0;
      // bit engine, mode 0
      if (xfer_q) begin
        if (tick) begin
          div_cnt_q <= '0;
          sclk_q    <= !sclk_q;
          if (sclk_q) begin
            // falling edge, next bit out and fill with idle ones
            bit_cnt_q <= bit_cnt_q + 3'd1;
            tx_q      <= {tx_q[6:0], 1'b1};
          end
        end else begin
          div_cnt_q <= div_cnt_q + 8'd1;
        end
      end
      case (state_q)
        sd_pkg::RD_IDLE: begin
          if (start_i) begin
            cs_n_q    <= 1'b0;
            xfer_q    <= 1'b1;
            div_cnt_q <= '0;
            tx_q      <= cmd_frame.b[5];
            cnt_q     <= 11'd5;
            state_q   <= sd_pkg::RD_CMD;
          end
        end
        sd_pkg::RD_CMD: begin
          if (byte_fin) begin
            if (cnt_q == '0) begin
              // tx is all ones now, polling starts
              state_q <= sd_pkg::RD_R1;
            end else begin
              tx_q  <= frame_q.b[cnt_q[2:0] - 3'd1];
              cnt_q <= cnt_q - 11'd1;
            end
          end
        end
        sd_pkg::RD_R1: begin
          if (byte_fin) begin
            if (rx_q == 8'h00) begin
              state_q <= sd_pkg::RD_TOKEN;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 11'd1;
            end
          end
        end
        sd_pkg::RD_TOKEN: begin
          if (byte_fin) begin
            if (rx_q == sd_pkg::DATA_TOKEN) begin
              state_q <= sd_pkg::RD_DATA;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 11'd1;
            end
          end
        end
        sd_pkg::RD_DATA: begin
          if (byte_fin) begin
            byte_en_o <= 1'b1;
            if (cnt_q == 11'(sd_pkg::SECTOR_BYTES - 1)) begin
              state_q <= sd_pkg::RD_CRC;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 11'd1;
            end
          end
        end
        sd_pkg::RD_CRC: begin
          if (byte_fin) begin
            cnt_q <= cnt_q + 11'd1;
          end
        end
        default: state_q <= sd_pkg::RD_IDLE;
      endcase
      // release the card and report
      if (fin_ok || fin_fail) begin
        state_q <= sd_pkg::RD_IDLE;
        xfer_q  <= 1'b0;
        cs_n_q  <= 1'b1;
        done_o  <= 1'b1;
        fail_o  <= fin_fail;
      end
    end
  end

  // datapath, sampled on rising sd clock
  always_ff @(posedge clk) begin
    if (xfer_q && tick && !sclk_q) begin
      rx_q <= {rx_q[6:0], sd_miso_i};
    end
    if (state_q == sd_pkg::RD_IDLE && start_i) begin
      frame_q <= cmd_frame;
    end
    if (state_q == sd_pkg::RD_DATA && byte_fin) begin
      byte_o      <= rx_q;
      byte_addr_o <= cnt_q[8:0];
    end
  end

  assign busy_o    = (state_q != sd_pkg::RD_IDLE);
  assign sd_clk_o  = sclk_q;
  assign sd_mosi_o = tx_q[7];
  assign sd_cs_n_o = cs_n_q;

  // the card clock only runs while the card is selected
  a_clk_cs : assert property (@(posedge clk) disable iff (!rst_n) sclk_q |-> !cs_n_q);

endmodule

//--- hdl/sd_lane.sv
// one card lane: idle/read fsm, sector buffer, read pointer
// wraps a single spi reader
`timescale 1ns/1ps

module sd_lane (
  input  logic     clk,
  input  logic     rst_n,
  lane_ctl_if.lane ctl,
  output logic     sd_clk_o,
  output logic     sd_mosi_o,
  output logic     sd_cs_n_o,
  input  logic     sd_miso_i
);

  logic [7:0]  buf_mem [sd_pkg::SECTOR_BYTES];
  logic [8:0]  ptr_q;
  // fsm state, high in read
  logic        reading_q;
  logic        err_q;
  logic        rd_start_q;
  logic [31:0] rd_sector_q;
  logic        rd_busy;
  logic        rd_done;
  logic        rd_fail;
  logic        rd_byte_en;
  logic [8:0]  rd_addr;
  logic [7:0]  rd_byte;

  // strobes only count while idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reading_q  <= 1'b0;
      err_q      <= 1'b0;
      ptr_q      <= '0;
      rd_start_q <= 1'b0;
    end else begin
      rd_start_q <= 1'b0;
      if (!reading_q) begin
        if (ctl.start) begin
          err_q      <= 1'b0;
          ptr_q      <= '0;
          rd_start_q <= 1'b1;
          reading_q  <= 1'b1;
        end else if (ctl.next) begin
          // 511 rolls over to 0
          ptr_q <= ptr_q + 9'd1;
        end
      end else if (rd_done) begin
        reading_q <= 1'b0;
        err_q     <= rd_fail;
      end
    end
  end

  // sector latched at start, the dispatcher copy is shared
  always_ff @(posedge clk) begin
    if (!reading_q && ctl.start) begin
      rd_sector_q <= ctl.sector;
    end
  end

  // fill at the reader's address, pointer stays at 0
  always_ff @(posedge clk) begin
    if (reading_q && rd_byte_en) begin
      buf_mem[rd_addr] <= rd_byte;
    end
  end

  assign ctl.data = buf_mem[ptr_q];
  assign ctl.busy = reading_q;
  assign ctl.err  = err_q;

  sd_spi_reader u_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (rd_start_q),
    .sector_i    (rd_sector_q),
    .busy_o      (rd_busy),
    .done_o      (rd_done),
    .fail_o      (rd_fail),
    .byte_en_o   (rd_byte_en),
    .byte_addr_o (rd_addr),
    .byte_o      (rd_byte),
    .sd_clk_o    (sd_clk_o),
    .sd_mosi_o   (sd_mosi_o),
    .sd_cs_n_o   (sd_cs_n_o),
    .sd_miso_i   (sd_miso_i)
  );

  // reader activity stays inside the lane's read state
  a_no_idle_byte : assert property (@(posedge clk) disable iff (!rst_n)
    rd_byte_en |-> reading_q);
  a_busy_in_read : assert property (@(posedge clk) disable iff (!rst_n)
    rd_busy |-> reading_q);

endmodule

//--- hdl/data_collect.sv
// output side: byte and error of the selected lane, busy of every lane
`timescale 1ns/1ps

module data_collect (
  input  logic [host_pkg::LANE_W-1:0]    lane_sel_i,
  lane_ctl_if.coll                       lanes_i [host_pkg::NUM_LANES],
  output logic [7:0]                     data_o,
  output logic                           err_o,
  output logic [host_pkg::NUM_LANES-1:0] busy_o
);

  // per-lane byte and error that the live select indexes
  logic [7:0] data_v [host_pkg::NUM_LANES];
  logic [host_pkg::NUM_LANES-1:0] err_v;

  for (genvar g = 0; g < host_pkg::NUM_LANES; g++) begin : g_gather
    assign data_v[g] = lanes_i[g].data;
    assign err_v[g]  = lanes_i[g].err;
    assign busy_o[g] = lanes_i[g].busy;
  end

  // purely combinational mux on the live select
  assign data_o = data_v[lane_sel_i];
  assign err_o  = err_v[lane_sel_i];

endmodule

//--- hdl/sd_array.sv
// top level: dispatcher, generated card lanes, output collector
// plain ports, one spi link per lane
`timescale 1ns/1ps

module sd_array (
  input  logic                           clk,
  input  logic                           rst_n,
  input  host_pkg::host_cmd_e            cmd_i,
  input  logic [host_pkg::LANE_W-1:0]    lane_sel_i,
  input  logic [31:0]                    sector_address_i,
  output logic [7:0]                     data_o,
  output logic [host_pkg::NUM_LANES-1:0] busy_o,
  output logic                           err_o,
  output logic [host_pkg::NUM_LANES-1:0] sd_clk_o,
  output logic [host_pkg::NUM_LANES-1:0] sd_mosi_o,
  output logic [host_pkg::NUM_LANES-1:0] sd_cs_n_o,
  input  logic [host_pkg::NUM_LANES-1:0] sd_miso_i
);

  // one control bundle per lane
  lane_ctl_if lane_bus [host_pkg::NUM_LANES] ();

  cmd_dispatch u_dispatch (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_i            (cmd_i),
    .lane_sel_i       (lane_sel_i),
    .sector_address_i (sector_address_i),
    .lanes_o          (lane_bus)
  );

  for (genvar g = 0; g < host_pkg::NUM_LANES; g++) begin : g_lane
    sd_lane u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctl       (lane_bus[g]),
      .sd_clk_o  (sd_clk_o[g]),
      .sd_mosi_o (sd_mosi_o[g]),
      .sd_cs_n_o (sd_cs_n_o[g]),
      .sd_miso_i (sd_miso_i[g])
    );
  end

  data_collect u_collect (
    .lane_sel_i (lane_sel_i),
    .lanes_i    (lane_bus),
    .data_o     (data_o),
    .err_o      (err_o),
    .busy_o     (busy_o)
  );

endmodule

//--- dv/sd_card_model.sv
// behavioural spi-mode sd card for one lane
// answers cmd17 with r1, a random token gap, a pattern sector and two crc bytes
`timescale 1ns/1ps

module sd_card_model #(
  parameter int LANE = 0
) (
  input  logic sd_clk_i,
  input  logic sd_mosi_i,
  input  logic sd_cs_n_i,
  input  logic fault_i,
  output logic sd_miso_o
);

  // last 48 bits seen on mosi
  logic [47:0] frame_q = '1;
  int          in_bits = 0;
  int          out_edges = 0;
  // msb is the bit on miso
  logic [7:0]  out_sh = 8'hFF;
  logic [7:0]  resp_q [$];

  // data byte idx of a sector on this lane
  function automatic logic [7:0] data_byte(input logic [31:0] sector, input int idx);
    logic [7:0] key;
    key = 8'(LANE * 8'h5A);
    return sector[7:0] ^ 8'(idx) ^ key;
  endfunction

  // byte stream for one cmd17
  task automatic queue_reply(input logic [31:0] sector);
    int gap;
    gap = $urandom_range(20, 1);
    // r1 comes after one filler byte
    resp_q.push_back(8'hFF);
    if (fault_i) begin
      // illegal command bit, no data follows
      resp_q.push_back(8'h04);
    end else begin
      resp_q.push_back(8'h00);
      repeat (gap) begin
        resp_q.push_back(8'hFF);
      end
      resp_q.push_back(8'hFE);
      for (int i = 0; i < 512; i++) begin
        resp_q.push_back(data_byte(sector, i));
      end
      // crc bytes, never checked by the host
      resp_q.push_back(8'hC3);
      resp_q.push_back(8'h3C);
    end
  endtask

  always @(posedge sd_clk_i or negedge sd_clk_i or posedge sd_cs_n_i) begin
    if (sd_cs_n_i) begin
      // deselect drops whatever is still pending
      in_bits   = 0;
      out_edges = 0;
      out_sh    = 8'hFF;
      resp_q.delete();
    end else if (sd_clk_i) begin
      // rising edge, sample mosi
      frame_q = {frame_q[46:0], sd_mosi_i};
      in_bits++;
      if (in_bits == 48 && frame_q[47:46] == 2'b01 &&
          frame_q[45:40] == 6'd17 && frame_q[0]) begin
        queue_reply(frame_q[39:8]);
      end
    end else begin
      // falling edge, every eighth one starts a new byte
      out_edges++;
      if (out_edges % 8 == 0) begin
        out_sh = 8'hFF;
        if (resp_q.size() > 0) begin
          out_sh = resp_q.pop_front();
        end
      end else begin
        out_sh = {out_sh[6:0], 1'b1};
      end
    end
  end

  assign sd_miso_o = sd_cs_n_i ? 1'b1 : out_sh[7];

endmodule

//--- dv/tb_sd_array.sv
// testbench for the two-lane sector reader
// clock, reset, card models, reference model and random checks
`timescale 1ns/1ps

module tb_sd_array;

  localparam int NL = host_pkg::NUM_LANES;
  // one full read is about 17k cycles
  localparam int BUSY_LIMIT = 40000;

  logic                        clk;
  logic                        rst_n;
  host_pkg::host_cmd_e         cmd;
  logic [host_pkg::LANE_W-1:0] sel;
  logic [31:0]                 addr;
  logic [7:0]                  data_o;
  logic [NL-1:0]               busy_o;
  logic                        err_o;
  logic [NL-1:0]               sd_clk;
  logic [NL-1:0]               sd_mosi;
  logic [NL-1:0]               sd_cs_n;
  logic [NL-1:0]               sd_miso;
  logic [NL-1:0]               fault;

  // reference state per lane
  logic [31:0] sector_m [NL];
  logic [8:0]  ptr_m [NL];
  logic        err_m [NL];
  logic        busy_m [NL];
  int          checks;
  int          errors;

  sd_array uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_i            (cmd),
    .lane_sel_i       (sel),
    .sector_address_i (addr),
    .data_o           (data_o),
    .busy_o           (busy_o),
    .err_o            (err_o),
    .sd_clk_o         (sd_clk),
    .sd_mosi_o        (sd_mosi),
    .sd_cs_n_o        (sd_cs_n),
    .sd_miso_i        (sd_miso)
  );

  for (genvar g = 0; g < NL; g++) begin : g_card
    sd_card_model #(.LANE(g)) u_card (
      .sd_clk_i  (sd_clk[g]),
      .sd_mosi_i (sd_mosi[g]),
      .sd_cs_n_i (sd_cs_n[g]),
      .fault_i   (fault[g]),
      .sd_miso_o (sd_miso[g])
    );
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // expected byte is the low sector byte xor index xor lane key
  function automatic logic [7:0] exp_byte(input logic [host_pkg::LANE_W-1:0] lane,
                                          input logic [31:0] sector, input logic [8:0] idx);
    logic [7:0] key;
    key = (lane != 0) ? 8'h5A : 8'h00;
    return sector[7:0] ^ idx[7:0] ^ key;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int mark);
    if (errors == mark) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - mark);
    end
  endtask

  // one command cycle that the dut samples on the second edge
  task automatic send_cmd(input host_pkg::host_cmd_e c,
                          input logic [host_pkg::LANE_W-1:0] lane, input logic [31:0] sector);
    @(posedge clk);
    cmd  <= c;
    sel  <= lane;
    addr <= sector;
    @(posedge clk);
    cmd  <= host_pkg::CMD_IDLE;
  endtask

  task automatic select_lane(input logic [host_pkg::LANE_W-1:0] lane);
    @(posedge clk);
    sel <= lane;
    @(negedge clk);
  endtask

  // poll busy at negedges until it reaches level
  task automatic wait_busy(input logic [host_pkg::LANE_W-1:0] lane, input logic level,
                           input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (busy_o[lane] !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (busy_o[lane] !== level) begin
      errors++;
      $display("timeout: busy_o[%0d] did not reach %0b within %0d cycles", lane, level, limit);
    end
  endtask

  task automatic check_byte(input logic [host_pkg::LANE_W-1:0] lane);
    @(negedge clk);
    check_value("data_o", 32'(data_o), 32'(exp_byte(lane, sector_m[lane], ptr_m[lane])));
  endtask

  // pointer moves two cycles after the command and only in an idle lane
  task automatic next_byte(input logic [host_pkg::LANE_W-1:0] lane);
    send_cmd(host_pkg::CMD_NEXT, lane, 32'h0);
    @(posedge clk);
    if (!busy_m[lane]) begin
      ptr_m[lane] = ptr_m[lane] + 9'd1;
    end
  endtask

  task automatic sweep_bytes(input logic [host_pkg::LANE_W-1:0] lane, input int count);
    for (int i = 0; i < count; i++) begin
      next_byte(lane);
      check_byte(lane);
    end
  endtask

  task automatic start_read(input logic [host_pkg::LANE_W-1:0] lane, input logic [31:0] sector);
    send_cmd(host_pkg::CMD_READ, lane, sector);
    sector_m[lane] = sector;
    ptr_m[lane]    = '0;
    err_m[lane]    = 1'b0;
    busy_m[lane]   = 1'b1;
    wait_busy(lane, 1'b1, 8);
  endtask

  task automatic finish_read(input logic [host_pkg::LANE_W-1:0] lane);
    wait_busy(lane, 1'b0, BUSY_LIMIT);
    busy_m[lane] = 1'b0;
    // a faulty card is the only source of a failed read
    err_m[lane] = fault[lane];
    select_lane(lane);
    check_value("err_o", 32'(err_o), 32'(err_m[lane]));
    if (!err_m[lane]) begin
      check_byte(lane);
    end
  endtask

  // random nexts on the idle lane and dropped commands on the busy one
  task automatic cross_traffic(input logic [host_pkg::LANE_W-1:0] busy_lane,
                               input logic [host_pkg::LANE_W-1:0] idle_lane, input int iters);
    for (int i = 0; i < iters; i++) begin
      if ($urandom_range(3, 0) == 0) begin
        if ($urandom_range(1, 0) == 1) begin
          send_cmd(host_pkg::CMD_READ, busy_lane, $urandom());
        end else begin
          send_cmd(host_pkg::CMD_NEXT, busy_lane, 32'h0);
        end
        @(negedge clk);
        check_value($sformatf("busy_o[%0d]", busy_lane), 32'(busy_o[busy_lane]), 32'h1);
      end else begin
        next_byte(idle_lane);
        check_byte(idle_lane);
      end
    end
  endtask

  initial begin
    logic [host_pkg::LANE_W-1:0] lane;
    int mark;
    void'($urandom(21901));
    checks = 0;
    errors = 0;
    rst_n  = 1'b0;
    cmd    = host_pkg::CMD_IDLE;
    sel    = '0;
    addr   = '0;
    fault  = '0;
    for (int i = 0; i < NL; i++) begin
      sector_m[i] = '0;
      ptr_m[i]    = '0;
      err_m[i]    = 1'b0;
      busy_m[i]   = 1'b0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    mark = errors;
    @(negedge clk);
    check_value("busy_o", 32'(busy_o), 32'h0);
    check_value("err_o", 32'(err_o), 32'h0);
    check_value("sd_cs_n_o", 32'(sd_cs_n), 32'(2'b11));
    check_value("sd_clk_o", 32'(sd_clk), 32'h0);
    // idle mosi is high
    check_value("sd_mosi_o", 32'(sd_mosi), 32'(2'b11));
    report_test("reset_state", mark);

    mark = errors;
    for (int l = 0; l < NL; l++) begin
      lane = l[host_pkg::LANE_W-1:0];
      start_read(lane, $urandom());
      finish_read(lane);
      sweep_bytes(lane, 511);
    end
    report_test("single_read", mark);

    // the 512th next wraps 511 back to 0
    mark = errors;
    for (int l = 0; l < NL; l++) begin
      lane = l[host_pkg::LANE_W-1:0];
      sweep_bytes(lane, 1);
    end
    report_test("pointer_wrap", mark);

    mark = errors;
    start_read(1'b0, $urandom());
    cross_traffic(1'b0, 1'b1, 40);
    finish_read(1'b0);
    start_read(1'b1, $urandom());
    cross_traffic(1'b1, 1'b0, 40);
    finish_read(1'b1);
    sweep_bytes(1'b0, 512);
    sweep_bytes(1'b1, 512);
    report_test("independent_lanes", mark);

    mark = errors;
    @(posedge clk);
    fault[1] <= 1'b1;
    start_read(1'b1, $urandom());
    finish_read(1'b1);
    select_lane(1'b0);
    check_value("err_o lane 0", 32'(err_o), 32'h0);
    @(posedge clk);
    fault[1] <= 1'b0;
    start_read(1'b1, $urandom());
    finish_read(1'b1);
    sweep_bytes(1'b1, 512);
    report_test("card_error", mark);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/sd_pkg.sv
hdl/host_pkg.sv
hdl/lane_ctl_if.sv
hdl/cmd_dispatch.sv
hdl/sd_spi_reader.sv
hdl/sd_lane.sv
hdl/data_collect.sv
hdl/sd_array.sv
dv/sd_card_model.sv
dv/tb_sd_array.sv

//--- run.sh
#!/bin/sh
# build and run the sd_array testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_sd_array -f compile.f -o tb_sd_array

out=$(./obj_dir/tb_sd_array)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"
